// File: rtl/vid_pkg.sv
package vid_pkg;

    // bytes per rgb pixel on the wire
    localparam int PIX_BYTES = 3;

    // default picture geometry, 1080p
    localparam int DEF_IMG_WIDTH  = 1920;
    localparam int DEF_IMG_HEIGHT = 1080;

    // one 24-bit rgb pixel, red in the top byte
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    // pixel with its write strobe
    typedef struct packed {
        logic   valid;
        pixel_t pix;
    } pix_beat_t;

endpackage

// File: rtl/udp_img_pkg.sv
package udp_img_pkg;

    localparam logic [31:0] IMG_MAGIC = 32'hAA0055FF;  // start of every image header
    localparam int HDR_BYTES = 16;
    localparam int DEF_PKT_PAYLOAD = 1440;  // payload bytes per udp packet

    // image header, magic sits in the low bytes so it goes out first
    typedef struct packed {
        logic [31:0] payload_size;
        logic [15:0] pkt_seq;  // packet number inside the picture, from 1
        logic [15:0] pic_seq;
        logic [15:0] height;
        logic [15:0] width;
        logic [31:0] magic;
    } img_hdr_t;

    // same header word, seen as fields or as bytes
    // bytes[0] is the least significant byte and leaves first
    typedef union packed {
        img_hdr_t                       fields;
        logic [HDR_BYTES-1:0][7:0]      bytes;
    } img_hdr_u;

    // what the byte serializer loads on the next edge
    typedef enum logic [1:0] {
        PH_IDLE    = 2'd0,
        PH_HEADER  = 2'd1,
        PH_PAYLOAD = 2'd2
    } tx_phase_t;

    // transmit side toward the udp stack
    typedef struct packed {
        logic       req;
        logic       valid;
        logic [7:0] data;
    } udp_tx_t;

endpackage

// File: rtl/pixel_fifo.sv
`timescale 1ns/100ps

module pixel_fifo #(
    parameter int FIFO_AW = 10
) (
    input  logic               clk_125,
    input  logic               reset,
    input  logic               i_clear,
    input  vid_pkg::pix_beat_t i_push,
    input  logic               i_pop,
    output vid_pkg::pixel_t    o_head,
    output logic               o_not_empty,
    output logic [FIFO_AW:0]   o_level
);
    import vid_pkg::*;

    localparam int DEPTH = 1 << FIFO_AW;

    pixel_t             mem [DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full        = count[FIFO_AW];  // count == DEPTH
    assign o_not_empty = (count != '0);
    assign o_level     = count;
    assign do_push     = i_push.valid && !full;
    assign do_pop      = i_pop && o_not_empty;

    // show-ahead, head is whatever rd_ptr points at
    assign o_head = mem[rd_ptr];

    always_ff @(posedge clk_125) begin
        if (do_push) begin
            mem[wr_ptr] <= i_push.pix;
        end
    end

    always_ff @(posedge clk_125 or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_clear) begin  // vsync drops what is left of the old frame
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // pixels lost to overflow would shift every later packet
    a_no_push_full: assert property (@(posedge clk_125) disable iff (reset)
        !(i_push.valid && full && !i_clear))
        else $error("pixel fifo overflow");

    a_no_pop_empty: assert property (@(posedge clk_125) disable iff (reset)
        !(i_pop && !o_not_empty && !i_clear))
        else $error("pixel fifo underflow");

endmodule

// File: rtl/img_seq_regs.sv
`timescale 1ns/100ps

module img_seq_regs #(
    parameter int IMG_WIDTH   = vid_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT  = vid_pkg::DEF_IMG_HEIGHT,
    parameter int PKT_PAYLOAD = udp_img_pkg::DEF_PKT_PAYLOAD
) (
    input  logic                  clk_125,
    input  logic                  reset,
    input  logic                  i_new_frame,
    input  logic                  i_new_packet,
    output udp_img_pkg::img_hdr_u o_hdr,
    output logic                  o_last_packet
);
    import udp_img_pkg::*;

    // three bytes per rgb pixel
    localparam int PKTS_PER_FRAME = IMG_WIDTH * IMG_HEIGHT * 3 / PKT_PAYLOAD;

    logic [15:0] pic_seq;
    logic [15:0] pkt_seq;

    always_ff @(posedge clk_125 or posedge reset) begin
        if (reset) begin
            pic_seq <= '0;
            pkt_seq <= '0;
        end else if (i_new_frame) begin
            pic_seq <= pic_seq + 1'b1;  // receiver shows pictures in this order
            pkt_seq <= '0;
        end else if (i_new_packet) begin
            pkt_seq <= pkt_seq + 1'b1;
        end
    end

    // header word, rebuilt from the counters every cycle
    always_comb begin
        o_hdr.fields.magic        = IMG_MAGIC;
        o_hdr.fields.width        = 16'(IMG_WIDTH);
        o_hdr.fields.height       = 16'(IMG_HEIGHT);
        o_hdr.fields.pic_seq      = pic_seq;
        o_hdr.fields.pkt_seq      = pkt_seq;
        o_hdr.fields.payload_size = 32'(PKT_PAYLOAD);
    end

    assign o_last_packet = (pkt_seq == 16'(PKTS_PER_FRAME));  // frame fully sent

endmodule

// File: rtl/img_tx_fsm.sv
`timescale 1ns/100ps

module img_tx_fsm #(
    parameter int PKT_PAYLOAD = udp_img_pkg::DEF_PKT_PAYLOAD,
    parameter int FIFO_AW     = 10
) (
    input  logic                   clk_125,
    input  logic                   reset,
    input  logic                   i_vs,
    input  logic                   i_udp_busy,
    input  logic [FIFO_AW:0]       i_level,
    input  logic                   i_last_packet,
    output logic                   o_new_frame,
    output logic                   o_new_packet,
    output udp_img_pkg::tx_phase_t o_phase,
    output logic [3:0]             o_hdr_idx,
    output logic                   o_req,
    output logic                   o_valid
);
    import udp_img_pkg::*;

    localparam int PKT_BYTES  = HDR_BYTES + PKT_PAYLOAD;
    localparam int PKT_PIXELS = PKT_PAYLOAD / 3;
    localparam int CNT_W      = $clog2(PKT_BYTES);

    localparam logic [CNT_W-1:0] HDR_LAST = CNT_W'(HDR_BYTES - 1);
    localparam logic [CNT_W-1:0] PKT_LAST = CNT_W'(PKT_BYTES - 1);
    localparam logic [FIFO_AW:0] FILL_MIN = (FIFO_AW + 1)'(PKT_PIXELS);

    typedef enum logic [2:0] {
        S_SYNC_1,
        S_SYNC_2,
        S_SYNC_3,
        S_WAIT,
        S_ACK,
        S_HEADER,
        S_PAYLOAD,
        S_END
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] byte_cnt;  // bytes handed out in this packet

    // header byte index rides on the low bits of the packet byte count
    assign o_hdr_idx = byte_cnt[3:0];

    always_ff @(posedge clk_125 or posedge reset) begin
        if (reset) begin
            state        <= S_SYNC_1;
            byte_cnt     <= '0;
            o_phase      <= PH_IDLE;
            o_req        <= 1'b0;
            o_valid      <= 1'b0;
            o_new_frame  <= 1'b0;
            o_new_packet <= 1'b0;
        end else begin
            o_new_frame  <= 1'b0;
            o_new_packet <= 1'b0;
            case (state)
                S_SYNC_1: begin
                    if (i_vs) begin  // new picture starts
                        o_new_frame <= 1'b1;
                        state       <= S_SYNC_2;
                    end
                end
                S_SYNC_2: begin
                    if (!i_vs) begin
                        state <= S_SYNC_3;
                    end
                end
                S_SYNC_3: begin
                    state <= S_WAIT;  // one settle cycle
                end
                S_WAIT: begin
                    byte_cnt <= '0;
                    // stack idle and a whole packet of pixels buffered
                    if (!i_udp_busy && i_level >= FILL_MIN) begin
                        o_req   <= 1'b1;
                        o_phase <= PH_HEADER;  // byte 0 loads on the ack edge
                        state   <= S_ACK;
                    end
                end
                S_ACK: begin
                    if (i_udp_busy) begin
                        o_req        <= 1'b0;
                        o_valid      <= 1'b1;
                        o_new_packet <= 1'b1;
                        byte_cnt     <= byte_cnt + 1'b1;
                        state        <= S_HEADER;
                    end
                end
                S_HEADER: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == HDR_LAST) begin
                        o_phase <= PH_PAYLOAD;
                        state   <= S_PAYLOAD;
                    end
                end
                S_PAYLOAD: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == PKT_LAST) begin
                        o_phase <= PH_IDLE;
                        state   <= S_END;
                    end
                end
                S_END: begin
                    o_valid <= 1'b0;
                    // stack still busy means the frame is on the wire
                    if (!i_udp_busy) begin
                        state <= i_last_packet ? S_SYNC_1 : S_WAIT;
                    end
                end
                default: state <= S_SYNC_1;
            endcase
        end
    end

    // pixels go out as whole rgb triples and a packet must fit in the fifo
    if (PKT_PAYLOAD % 3 != 0) begin : g_bad_payload
        $error("PKT_PAYLOAD must be a multiple of 3");
    end
    if (PKT_PIXELS > (1 << FIFO_AW)) begin : g_small_fifo
        $error("pixel fifo smaller than one packet");
    end

    // request and data phase never overlap
    a_req_not_valid: assert property (@(posedge clk_125) disable iff (reset)
        !(o_req && o_valid))
        else $error("req high during valid");

endmodule

// File: rtl/img_byte_serializer.sv
`timescale 1ns/100ps

module img_byte_serializer (
    input  logic                   clk_125,
    input  logic                   reset,
    input  udp_img_pkg::tx_phase_t i_phase,
    input  logic [3:0]             i_hdr_idx,
    input  udp_img_pkg::img_hdr_u  i_hdr,
    input  vid_pkg::pixel_t        i_head,
    output logic                   o_pop,
    output logic [7:0]             o_data
);
    import vid_pkg::*;
    import udp_img_pkg::*;

    logic [1:0] byte_idx;  // 0 red, 1 green, 2 blue
    logic [7:0] pix_byte;

    always_comb begin
        case (byte_idx)
            2'd0:    pix_byte = i_head.red;
            2'd1:    pix_byte = i_head.green;
            default: pix_byte = i_head.blue;
        endcase
    end

    // pixel is done once its blue byte is taken
    assign o_pop = (i_phase == PH_PAYLOAD) && (byte_idx == 2'(PIX_BYTES - 1));

    always_ff @(posedge clk_125 or posedge reset) begin
        if (reset) begin
            byte_idx <= '0;
            o_data   <= '0;
        end else begin
            case (i_phase)
                PH_HEADER: begin
                    o_data   <= i_hdr.bytes[i_hdr_idx];
                    byte_idx <= '0;
                end
                PH_PAYLOAD: begin
                    o_data   <= pix_byte;
                    byte_idx <= o_pop ? 2'd0 : byte_idx + 1'b1;
                end
                default: begin
                    o_data   <= '0;
                    byte_idx <= '0;
                end
            endcase
        end
    end

endmodule

// File: rtl/img_udp_packetizer.sv
`timescale 1ns/100ps

module img_udp_packetizer #(
    parameter int IMG_WIDTH   = vid_pkg::DEF_IMG_WIDTH,
    parameter int IMG_HEIGHT  = vid_pkg::DEF_IMG_HEIGHT,
    parameter int PKT_PAYLOAD = udp_img_pkg::DEF_PKT_PAYLOAD,
    parameter int FIFO_AW     = 10
) (
    input  logic                 clk_125,
    input  logic                 reset,
    input  logic                 i_vs,
    input  vid_pkg::pix_beat_t   i_pix,
    input  logic                 i_udp_busy,
    output udp_img_pkg::udp_tx_t o_udp
);
    import vid_pkg::*;
    import udp_img_pkg::*;

    pixel_t           fifo_head;
    logic             fifo_not_empty;
    logic [FIFO_AW:0] fifo_level;
    logic             fifo_pop;
    logic             new_frame;
    logic             new_packet;
    logic             last_packet;
    img_hdr_u         hdr;
    tx_phase_t        phase;
    logic [3:0]       hdr_idx;
    logic             tx_req;
    logic             tx_valid;
    logic [7:0]       tx_data;

    pixel_fifo #(
        .FIFO_AW(FIFO_AW)
    ) u_pixel_fifo (
        .clk_125    (clk_125),
        .reset      (reset),
        .i_clear    (i_vs),  // each vsync starts the buffer empty
        .i_push     (i_pix),
        .i_pop      (fifo_pop),
        .o_head     (fifo_head),
        .o_not_empty(fifo_not_empty),
        .o_level    (fifo_level)
    );

    img_seq_regs #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .PKT_PAYLOAD(PKT_PAYLOAD)
    ) u_img_seq_regs (
        .clk_125      (clk_125),
        .reset        (reset),
        .i_new_frame  (new_frame),
        .i_new_packet (new_packet),
        .o_hdr        (hdr),
        .o_last_packet(last_packet)
    );

    img_tx_fsm #(
        .PKT_PAYLOAD(PKT_PAYLOAD),
        .FIFO_AW    (FIFO_AW)
    ) u_img_tx_fsm (
        .clk_125      (clk_125),
        .reset        (reset),
        .i_vs         (i_vs),
        .i_udp_busy   (i_udp_busy),
        .i_level      (fifo_level),
        .i_last_packet(last_packet),
        .o_new_frame  (new_frame),
        .o_new_packet (new_packet),
        .o_phase      (phase),
        .o_hdr_idx    (hdr_idx),
        .o_req        (tx_req),
        .o_valid      (tx_valid)
    );

    img_byte_serializer u_img_byte_serializer (
        .clk_125  (clk_125),
        .reset    (reset),
        .i_phase  (phase),
        .i_hdr_idx(hdr_idx),
        .i_hdr    (hdr),
        .i_head   (fifo_head),
        .o_pop    (fifo_pop),
        .o_data   (tx_data)
    );

    assign o_udp = '{req: tx_req, valid: tx_valid, data: tx_data};

    // fill gate in the fsm must keep pixels ready for the whole payload
    a_payload_has_pixels: assert property (@(posedge clk_125) disable iff (reset)
        (phase == PH_PAYLOAD) |-> fifo_not_empty)
        else $error("payload phase with empty pixel fifo");

endmodule

// File: testbench/tb_img_udp_packetizer.sv
`timescale 1ns/100ps

module tb_img_udp_packetizer;
    import vid_pkg::*;
    import udp_img_pkg::*;

    localparam int IMG_WIDTH      = 8;
    localparam int IMG_HEIGHT     = 6;
    localparam int PKT_PAYLOAD    = 24;
    localparam int FIFO_AW        = 6;
    localparam int PKT_BYTES      = HDR_BYTES + PKT_PAYLOAD;
    localparam int PKT_PIXELS     = PKT_PAYLOAD / PIX_BYTES;
    localparam int PIX_PER_FRAME  = IMG_WIDTH * IMG_HEIGHT;
    localparam int PKTS_PER_FRAME = PIX_PER_FRAME / PKT_PIXELS;
    localparam int NUM_FRAMES     = 3;
    localparam int CLK_PERIOD     = 100;
    localparam int FRAME_NS       = 60000;
    localparam int WATCHDOG_NS    = NUM_FRAMES * FRAME_NS * 2;
    localparam logic [31:0] SEED  = 32'h826f452b;
    localparam logic [31:0] MAGIC_WORD = 32'hAA0055FF;  // first header word

    logic      clk_125;
    logic      reset;
    logic      i_vs;
    pix_beat_t i_pix;
    logic      i_udp_busy;
    udp_tx_t   o_udp;

    pixel_t      frame_pix [PIX_PER_FRAME];  // pixels of the frame on the wire
    logic [31:0] rng_stim;
    logic [31:0] rng_stack;
    int          err_cnt     = 0;
    int          pkt_total   = 0;
    int          byte_checks = 0;
    int          pic_expect  = 0;  // vsync pulses seen so far
    int          frame_pkts  = 0;
    int          byte_idx    = 0;
    int          pix_seen    = 0;  // strobes taken by the fifo since vsync
    logic        prev_vs, prev_req, prev_valid, prev_busy;
    logic [7:0]  exp_byte;

    img_udp_packetizer #(
        .IMG_WIDTH  (IMG_WIDTH),
        .IMG_HEIGHT (IMG_HEIGHT),
        .PKT_PAYLOAD(PKT_PAYLOAD),
        .FIFO_AW    (FIFO_AW)
    ) u_img_udp_packetizer (
        .clk_125   (clk_125),
        .reset     (reset),
        .i_vs      (i_vs),
        .i_pix     (i_pix),
        .i_udp_busy(i_udp_busy),
        .o_udp     (o_udp)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // header is sent lsb first, payload as r, g, b per pixel
    function automatic logic [7:0] expected_byte(input int pic, input int pkt, input int offs);
        pixel_t p;
        int     k;
        if (offs < HDR_BYTES) begin
            case (offs)
                0, 1, 2, 3: return 8'(MAGIC_WORD >> (8 * offs));
                4, 5:       return 8'(IMG_WIDTH >> (8 * (offs - 4)));
                6, 7:       return 8'(IMG_HEIGHT >> (8 * (offs - 6)));
                8, 9:       return 8'(pic >> (8 * (offs - 8)));
                10, 11:     return 8'(pkt >> (8 * (offs - 10)));
                default:    return 8'(PKT_PAYLOAD >> (8 * (offs - 12)));
            endcase
        end
        k = (pkt - 1) * PKT_PIXELS + (offs - HDR_BYTES) / PIX_BYTES;
        p = frame_pix[k];
        case ((offs - HDR_BYTES) % PIX_BYTES)
            0:       return p.red;
            1:       return p.green;
            default: return p.blue;
        endcase
    endfunction

    task automatic log_failure(input string msg);
        err_cnt++;
        $display("[FAIL] %0d ns: %s", $time, msg);
    endtask

    // random gaps of 0..3 cycles between strobes
    task automatic push_pixels(input int count, input bit record);
        pixel_t p;
        int     gap;
        for (int n = 0; n < count; n++) begin
            rng_stim = xorshift32(rng_stim);
            p = rng_stim[23:0];
            rng_stim = xorshift32(rng_stim);
            gap = rng_stim % 4;
            repeat (gap) begin
                @(posedge clk_125);
                i_pix <= '0;
            end
            @(posedge clk_125);
            i_pix <= '{valid: 1'b1, pix: p};
            if (record) begin
                frame_pix[n] = p;
            end
        end
        @(posedge clk_125);
        i_pix <= '0;
    endtask

    task automatic pulse_vsync();
        @(posedge clk_125);
        i_vs <= 1'b1;
        repeat (2) @(posedge clk_125);
        i_vs <= 1'b0;
    endtask

    initial begin
        clk_125 = 1'b0;
        forever #(CLK_PERIOD / 2) clk_125 = ~clk_125;
    end

    // udp stack model raising busy 1..4 cycles after req and dropping it 1..5 after valid
    initial begin
        int wait_cyc;
        i_udp_busy = 1'b0;
        rng_stack = {SEED[15:0], SEED[31:16]};
        @(negedge reset);
        forever begin
            @(posedge clk_125);
            if (o_udp.req) begin
                rng_stack = xorshift32(rng_stack);
                wait_cyc = rng_stack % 4;
                repeat (wait_cyc) @(posedge clk_125);
                i_udp_busy <= 1'b1;
                @(posedge clk_125);
                while (!o_udp.valid) @(posedge clk_125);
                while (o_udp.valid) @(posedge clk_125);
                rng_stack = xorshift32(rng_stack);
                wait_cyc = rng_stack % 5;
                repeat (wait_cyc) @(posedge clk_125);
                i_udp_busy <= 1'b0;
            end
        end
    end

    // samples pre-edge values, so DUT updates on this edge are not seen yet
    always @(posedge clk_125) begin
        if (reset) begin
            prev_vs    = 1'b0;
            prev_req   = 1'b0;
            prev_valid = 1'b0;
            prev_busy  = 1'b0;
        end else begin
            if (i_vs && !prev_vs) begin
                if (pic_expect > 0 && frame_pkts != PKTS_PER_FRAME) begin
                    log_failure($sformatf("frame %0d sent %0d packets", pic_expect, frame_pkts));
                end
                pic_expect++;
                frame_pkts = 0;
                pix_seen   = 0;
            end
            if (o_udp.req && o_udp.valid) begin
                log_failure("req and valid high together");
            end
            if (o_udp.req && !prev_req && prev_busy) begin
                log_failure("req raised while stack busy");
            end
            if (o_udp.req && !prev_req && pic_expect == 0) begin
                log_failure("req before the first vsync");
            end
            if (o_udp.req && !prev_req && pix_seen < (frame_pkts + 1) * PKT_PIXELS) begin
                log_failure("req before a full packet of pixels arrived");
            end
            if (o_udp.req && !prev_req && frame_pkts == PKTS_PER_FRAME) begin
                log_failure("req after the last packet of the frame");
            end
            if (o_udp.req && prev_req && prev_busy) begin
                log_failure("req still high after busy was seen");
            end
            if (!o_udp.req && prev_req && !prev_busy) begin
                log_failure("req dropped before busy was seen");
            end
            if (o_udp.valid) begin
                if (!prev_valid) begin
                    if (!prev_busy) begin
                        log_failure("valid started before busy");
                    end
                    frame_pkts++;
                    byte_idx = 0;
                end
                if (byte_idx < PKT_BYTES && frame_pkts <= PKTS_PER_FRAME) begin
                    exp_byte = expected_byte(pic_expect, frame_pkts, byte_idx);
                    if (o_udp.data !== exp_byte) begin
                        log_failure($sformatf("frame %0d packet %0d byte %0d: got %02h, exp %02h",
                            pic_expect, frame_pkts, byte_idx, o_udp.data, exp_byte));
                    end
                    byte_checks++;
                end
                byte_idx++;
            end else if (prev_valid) begin
                if (byte_idx != PKT_BYTES) begin
                    log_failure($sformatf("packet with %0d valid cycles", byte_idx));
                end
                pkt_total++;
            end
            if (i_pix.valid && !i_vs) begin
                pix_seen++;
            end
            prev_vs    = i_vs;
            prev_req   = o_udp.req;
            prev_valid = o_udp.valid;
            prev_busy  = i_udp_busy;
        end
    end

    initial begin
        reset = 1'b1;
        i_vs = 1'b0;
        i_pix = '0;
        rng_stim = SEED;
        repeat (3) @(posedge clk_125);
        reset <= 1'b0;
        @(posedge clk_125);
        if (o_udp.req || o_udp.valid || o_udp.data != 8'h00) begin
            log_failure("outputs not idle after reset");
        end
        push_pixels(10, 1'b0);  // no vsync yet, so no req
        repeat (20) @(posedge clk_125);
        for (int f = 1; f <= NUM_FRAMES; f++) begin
            pulse_vsync();
            push_pixels(PIX_PER_FRAME, 1'b1);
            while (pkt_total < f * PKTS_PER_FRAME) @(posedge clk_125);
            while (i_udp_busy) @(posedge clk_125);
            push_pixels(9, 1'b0);  // fsm parked in sync until the next vsync flushes these
            repeat (20) @(posedge clk_125);
        end
        if (frame_pkts != PKTS_PER_FRAME) begin
            log_failure($sformatf("last frame %0d sent %0d packets", pic_expect, frame_pkts));
        end
        $display("%0d packets, %0d bytes checked, %0d errors", pkt_total, byte_checks, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns with %0d packets sent", WATCHDOG_NS, pkt_total);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: img_udp_packetizer.f
rtl/vid_pkg.sv
rtl/udp_img_pkg.sv
rtl/pixel_fifo.sv
rtl/img_seq_regs.sv
rtl/img_tx_fsm.sv
rtl/img_byte_serializer.sv
rtl/img_udp_packetizer.sv
testbench/tb_img_udp_packetizer.sv

// File: Bender.yml
package:
  name: img_udp_packetizer

sources:
  - rtl/vid_pkg.sv
  - rtl/udp_img_pkg.sv
  - rtl/pixel_fifo.sv
  - rtl/img_seq_regs.sv
  - rtl/img_tx_fsm.sv
  - rtl/img_byte_serializer.sv
  - rtl/img_udp_packetizer.sv
  - target: test
    files:
      - testbench/tb_img_udp_packetizer.sv
